//--- verilog/tomasulo_defines.svh
`ifndef TOMASULO_DEFINES_SVH
`define TOMASULO_DEFINES_SVH

// width of every register, operand and result
`define XLEN 32

// station tag width, where tag 0 means the value is already present
// and tags 1 up to NUM_RS name the station that will produce it
`define TAG_WIDTH 3

// number of reservation stations feeding the single ALU
`define NUM_RS 4

// number of architectural registers, indexed by a 3 bit field
`define NUM_REGS 8

`endif

//--- verilog/tomasulo_pkg.sv
`default_nettype none

`include "tomasulo_defines.svh"

package tomasulo_pkg;

	typedef logic [`XLEN-1:0] data_t;
	typedef logic [`TAG_WIDTH-1:0] tag_t;
	typedef logic [2:0] reg_idx_t;

	// the sign bit picks the variant: sub, signed compare, arithmetic shift
	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SLL  = 3'd1,
		ALU_SLT  = 3'd2,
		ALU_XOR  = 3'd3,
		ALU_SRL  = 3'd4,
		ALU_OR   = 3'd5,
		ALU_AND  = 3'd6,
		ALU_PASS = 3'd7
	} alu_op_t;

	// one broadcast on the common data bus
	typedef struct packed {
		logic active;
		tag_t tag;
		data_t data;
	} cdb_t;

	// host word layout, issue words use op..rs2 and load words use rd and imm
	typedef struct packed {
		logic [15:0] imm;
		logic [2:0] rsvd;
		reg_idx_t rs2;
		reg_idx_t rs1;
		reg_idx_t rd;
		logic sign;
		alu_op_t op;
	} instr_word_t;

endpackage

`default_nettype wire

//--- verilog/rs_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// fields written into one reservation station when an instruction issues
interface rs_issue_if import tomasulo_pkg::*; ();

	// one cycle pulse, on the same edge as the wishbone ack
	logic enable;

	// q is the producer tag and v the value, one pair per source operand
	tag_t q1;
	data_t v1;
	tag_t q2;
	data_t v2;

	alu_op_t alu_op;
	logic alu_sign;
	reg_idx_t dest_reg;

	// station holds an instruction until its own tag is broadcast
	logic busy;

	modport issuer (
		output enable, q1, v1, q2, v2, alu_op, alu_sign, dest_reg,
		input busy
	);

	modport station (
		input enable, q1, v1, q2, v2, alu_op, alu_sign, dest_reg,
		output busy
	);

endinterface

`default_nettype wire

//--- verilog/issue_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "tomasulo_defines.svh"

module issue_unit import tomasulo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [2:0] adr,
	input data_t dat_w,
	output data_t dat_r,
	output logic ack,
	rs_issue_if.issuer issue [`NUM_RS],
	input cdb_t cdb
);

	localparam int SEL_W = $clog2(`NUM_RS);

	// architectural registers and the station each one waits on
	data_t regs [`NUM_REGS];
	tag_t reg_tag [`NUM_REGS];

	instr_word_t word;
	logic req;
	logic is_issue;
	logic is_load;
	logic accept;
	logic any_free;
	logic [SEL_W-1:0] free_idx;
	logic [`NUM_RS-1:0] busy_vec;
	logic [`NUM_RS-1:0] enable_vec;
	logic [`NUM_REGS-1:0] pending;
	tag_t new_tag;
	tag_t src1_tag;
	tag_t src2_tag;
	data_t src1_val;
	data_t src2_val;
	data_t read_data;

	assign word = instr_word_t'(dat_w);

	// ack is registered, so the cycle it is high never counts as a new request
	assign req = cyc && stb && !ack;
	assign is_issue = we && adr == 3'd0;
	assign is_load = we && adr == 3'd1;

	// issues wait for a free station, everything else goes through at once
	assign accept = req && (!is_issue || any_free);

	// lowest numbered free station wins
	always_comb begin
		any_free = 1'b0;
		free_idx = '0;
		for (int i = `NUM_RS - 1; i >= 0; i--) begin
			if (!busy_vec[i]) begin
				any_free = 1'b1;
				free_idx = SEL_W'(i);
			end
		end
	end

	assign new_tag = tag_t'(free_idx) + tag_t'(1);
	assign enable_vec = (accept && is_issue) ? (`NUM_RS'(1) << free_idx) : '0;

	// source lookup, taking the bus value when the producer broadcasts right now
	always_comb begin
		src1_tag = reg_tag[word.rs1];
		src1_val = regs[word.rs1];
		if (src1_tag != '0 && cdb.active && cdb.tag == src1_tag) begin
			src1_tag = '0;
			src1_val = cdb.data;
		end
		src2_tag = reg_tag[word.rs2];
		src2_val = regs[word.rs2];
		if (src2_tag != '0 && cdb.active && cdb.tag == src2_tag) begin
			src2_tag = '0;
			src2_val = cdb.data;
		end
	end

	for (genvar g = 0; g < `NUM_RS; g++) begin : g_issue
		assign busy_vec[g] = issue[g].busy;
		assign issue[g].enable = enable_vec[g];
		assign issue[g].q1 = src1_tag;
		assign issue[g].v1 = src1_val;
		assign issue[g].q2 = src2_tag;
		assign issue[g].v2 = src2_val;
		assign issue[g].alu_op = word.op;
		assign issue[g].alu_sign = word.sign;
		assign issue[g].dest_reg = word.rd;
	end

	always_comb begin
		for (int r = 0; r < `NUM_REGS; r++) begin
			pending[r] = reg_tag[r] != '0;
		end
	end

	// address 2 gives the pending mask, address 3 a register picked by dat_w
	always_comb begin
		read_data = '0;
		if (adr == 3'd2) begin
			read_data = data_t'(pending);
		end else if (adr == 3'd3) begin
			read_data = regs[reg_idx_t'(dat_w[2:0])];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			ack <= 1'b0;
			for (int r = 0; r < `NUM_REGS; r++) begin
				regs[r] <= '0;
				reg_tag[r] <= '0;
			end
		end else begin
			ack <= accept;
			// writeback only lands where the register still waits on that station
			for (int r = 0; r < `NUM_REGS; r++) begin
				if (cdb.active && reg_tag[r] != '0 && reg_tag[r] == cdb.tag) begin
					regs[r] <= cdb.data;
					reg_tag[r] <= '0;
				end
			end
			// a load overrides any outstanding producer of that register
			if (accept && is_load) begin
				regs[word.rd] <= {{(`XLEN - 16){word.imm[15]}}, word.imm};
				reg_tag[word.rd] <= '0;
			end
			// renaming the destination wins over a same cycle writeback
			if (accept && is_issue) begin
				reg_tag[word.rd] <= new_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !we) begin
			dat_r <= read_data;
		end
	end

	assert property (@(posedge clk) disable iff (!reset) $onehot0(enable_vec))
		else $error("[ERROR] issue_unit: more than one station enabled");

endmodule

`default_nettype wire

//--- verilog/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station import tomasulo_pkg::*; #(
	parameter int STATION_TAG = 1
) (
	input logic clk,
	input logic reset,
	rs_issue_if.station issue,
	input logic dispatched,
	input cdb_t cdb,
	output logic ready,
	output data_t v1,
	output data_t v2,
	output alu_op_t alu_op,
	output logic alu_sign,
	output reg_idx_t dest_reg
);

	// outstanding producer tags, zero once the value sits in v1 or v2
	tag_t q1;
	tag_t q2;

	// set once the ALU has taken this instruction, cleared when the station frees
	logic dispatched_q;

	tag_t watch1;
	tag_t watch2;
	logic cap1;
	logic cap2;
	logic freeing;

	// on the issue cycle the incoming tags are the ones to watch on the bus
	assign watch1 = issue.enable ? issue.q1 : q1;
	assign watch2 = issue.enable ? issue.q2 : q2;
	assign cap1 = cdb.active && watch1 != '0 && watch1 == cdb.tag;
	assign cap2 = cdb.active && watch2 != '0 && watch2 == cdb.tag;

	// our own result on the bus means the instruction is finished
	assign freeing = issue.busy && cdb.active && cdb.tag == tag_t'(STATION_TAG);

	assign ready = issue.busy && !dispatched_q && q1 == '0 && q2 == '0;

	always_ff @(posedge clk) begin
		if (!reset) begin
			issue.busy <= 1'b0;
			dispatched_q <= 1'b0;
			q1 <= '0;
			q2 <= '0;
		end else begin
			if (issue.enable) begin
				issue.busy <= 1'b1;
				dispatched_q <= 1'b0;
			end else if (freeing) begin
				issue.busy <= 1'b0;
				dispatched_q <= 1'b0;
			end else if (dispatched) begin
				dispatched_q <= 1'b1;
			end
			q1 <= cap1 ? '0 : (issue.enable ? issue.q1 : q1);
			q2 <= cap2 ? '0 : (issue.enable ? issue.q2 : q2);
		end
	end

	// bus data beats the issued value, which would be stale anyway
	always_ff @(posedge clk) begin
		if (cap1) begin
			v1 <= cdb.data;
		end else if (issue.enable) begin
			v1 <= issue.v1;
		end
		if (cap2) begin
			v2 <= cdb.data;
		end else if (issue.enable) begin
			v2 <= issue.v2;
		end
		if (issue.enable) begin
			alu_op <= issue.alu_op;
			alu_sign <= issue.alu_sign;
			dest_reg <= issue.dest_reg;
		end
	end

	// the issue unit must only pick a station that is free
	assert property (@(posedge clk) disable iff (!reset) issue.enable |-> !issue.busy)
		else $error("[ERROR] station %0d: enable while busy", STATION_TAG);

	assert property (@(posedge clk) disable iff (!reset) ready |-> issue.busy)
		else $error("[ERROR] station %0d: ready while idle", STATION_TAG);

	// the ALU may only take a station that reports ready
	assert property (@(posedge clk) disable iff (!reset) dispatched |-> ready)
		else $error("[ERROR] station %0d: dispatched while not ready", STATION_TAG);

endmodule

`default_nettype wire

//--- verilog/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "tomasulo_defines.svh"

module alu_unit import tomasulo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [`NUM_RS-1:0] ready,
	input data_t v1 [`NUM_RS],
	input data_t v2 [`NUM_RS],
	input alu_op_t alu_op [`NUM_RS],
	input logic [`NUM_RS-1:0] alu_sign,
	output logic [`NUM_RS-1:0] dispatched,
	input logic result_full,
	output logic result_valid,
	output tag_t result_tag,
	output data_t result_data
);

	localparam int SEL_W = $clog2(`NUM_RS);

	logic sel_valid;
	logic [SEL_W-1:0] sel_idx;
	logic fire;
	data_t alu_out;

	function automatic data_t alu_compute(input alu_op_t op, input logic sign,
		input data_t a, input data_t b);
		logic [4:0] shamt;
		logic lt;
		data_t res;
		// shifts only look at the low five bits of operand two
		shamt = b[4:0];
		lt = sign ? ($signed(a) < $signed(b)) : (a < b);
		case (op)
			ALU_ADD: res = sign ? a - b : a + b;
			ALU_SLL: res = a << shamt;
			ALU_SLT: res = data_t'(lt);
			ALU_XOR: res = a ^ b;
			ALU_SRL: begin
				if (sign) begin
					res = $signed(a) >>> shamt;
				end else begin
					res = a >> shamt;
				end
			end
			ALU_OR: res = a | b;
			ALU_AND: res = a & b;
			// ALU_PASS forwards operand one
			default: res = a;
		endcase
		return res;
	endfunction

	// fixed priority, lowest station number first
	always_comb begin
		sel_valid = 1'b0;
		sel_idx = '0;
		for (int i = `NUM_RS - 1; i >= 0; i--) begin
			if (ready[i]) begin
				sel_valid = 1'b1;
				sel_idx = SEL_W'(i);
			end
		end
	end

	// nothing leaves a station while the result stage still holds an entry
	assign fire = sel_valid && !result_full;
	assign dispatched = fire ? (`NUM_RS'(1) << sel_idx) : '0;
	assign alu_out = alu_compute(alu_op[sel_idx], alu_sign[sel_idx], v1[sel_idx], v2[sel_idx]);

	always_ff @(posedge clk) begin
		if (!reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= fire;
		end
	end

	// station index plus one is the tag the stations and registers wait on
	always_ff @(posedge clk) begin
		if (fire) begin
			result_tag <= tag_t'(sel_idx) + tag_t'(1);
			result_data <= alu_out;
		end
	end

	assert property (@(posedge clk) disable iff (!reset) $onehot0(dispatched))
		else $error("[ERROR] alu_unit: dispatched is not one-hot");

endmodule

`default_nettype wire

//--- verilog/cdb_result.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_result import tomasulo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic result_valid,
	input tag_t result_tag,
	input data_t result_data,
	output logic result_full,
	output cdb_t cdb
);

	// single holding entry that is also the bus driver
	logic active_q;
	tag_t tag_q;
	data_t data_q;

	// each result is shown for exactly one cycle and then dropped
	always_ff @(posedge clk) begin
		if (!reset) begin
			active_q <= 1'b0;
		end else begin
			active_q <= result_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (result_valid) begin
			tag_q <= result_tag;
			data_q <= result_data;
		end
	end

	assign cdb = {active_q, tag_q, data_q};

	// the ALU holds off while the entry is on the bus
	assign result_full = active_q;

	// tag 0 means value present, so it never names a producer
	assert property (@(posedge clk) disable iff (!reset) cdb.active |-> cdb.tag != '0)
		else $error("[ERROR] cdb_result: broadcast with tag 0");

endmodule

`default_nettype wire

//--- verilog/tomasulo_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tomasulo_defines.svh"

module tomasulo_top import tomasulo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [2:0] adr,
	input data_t dat_w,
	output data_t dat_r,
	output logic ack
);

	// one issue bundle per station
	rs_issue_if rs_if [`NUM_RS] ();

	cdb_t cdb;
	logic [`NUM_RS-1:0] rs_ready;
	logic [`NUM_RS-1:0] rs_sign;
	logic [`NUM_RS-1:0] rs_dispatched;
	data_t rs_v1 [`NUM_RS];
	data_t rs_v2 [`NUM_RS];
	alu_op_t rs_op [`NUM_RS];
	logic result_valid;
	logic result_full;
	tag_t result_tag;
	data_t result_data;

	issue_unit issue_i (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.issue(rs_if),
		.cdb(cdb)
	);

	// station g answers to tag g + 1
	for (genvar g = 0; g < `NUM_RS; g++) begin : g_rs
		reservation_station #(.STATION_TAG(g + 1)) rs_i (
			.clk(clk),
			.reset(reset),
			.issue(rs_if[g]),
			.dispatched(rs_dispatched[g]),
			.cdb(cdb),
			.ready(rs_ready[g]),
			.v1(rs_v1[g]),
			.v2(rs_v2[g]),
			.alu_op(rs_op[g]),
			.alu_sign(rs_sign[g]),
			.dest_reg()
		);
	end

	alu_unit alu_i (
		.clk(clk),
		.reset(reset),
		.ready(rs_ready),
		.v1(rs_v1),
		.v2(rs_v2),
		.alu_op(rs_op),
		.alu_sign(rs_sign),
		.dispatched(rs_dispatched),
		.result_full(result_full),
		.result_valid(result_valid),
		.result_tag(result_tag),
		.result_data(result_data)
	);

	cdb_result cdb_i (
		.clk(clk),
		.reset(reset),
		.result_valid(result_valid),
		.result_tag(result_tag),
		.result_data(result_data),
		.result_full(result_full),
		.cdb(cdb)
	);

endmodule

`default_nettype wire

//--- bench/tb_tomasulo_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tomasulo_defines.svh"

module tb_tomasulo_top import tomasulo_pkg::*; ();

	// about 200 bus transactions of two cycles each plus a few stalled issues stay far below this
	localparam int TIMEOUT_CYCLES = 4000;
	localparam logic [2:0] ADR_ISSUE = 3'd0;
	localparam logic [2:0] ADR_LOAD = 3'd1;
	localparam logic [2:0] ADR_PENDING = 3'd2;
	localparam logic [2:0] ADR_REG = 3'd3;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [2:0] adr;
	data_t dat_w;
	data_t dat_r;
	logic ack;

	// in-order view of the register file, which the DUT must match once idle
	data_t model [`NUM_REGS];
	integer seed;
	int cycles;
	int checks;
	int errors;
	int tests;

	tomasulo_top dut_i (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ack is a single cycle pulse
	assert property (@(posedge clk) disable iff (!reset) ack |=> !ack)
		else begin
			errors++;
			$display("[ERROR] %0t: ack stayed high for more than one cycle", $time);
		end

	// an ack only ever answers a request that the host raised
	assert property (@(posedge clk) disable iff (!reset) ack |-> $past(cyc && stb))
		else begin
			errors++;
			$display("[ERROR] %0t: ack without a bus request", $time);
		end

	// synchronous reset keeps ack low
	assert property (@(posedge clk) !reset |=> !ack)
		else begin
			errors++;
			$display("[ERROR] %0t: ack high after a reset cycle", $time);
		end

	// a broadcast always names one of the stations
	assert property (@(posedge clk) disable iff (!reset)
		dut_i.cdb.active |-> (dut_i.cdb.tag >= 1 && dut_i.cdb.tag <= `NUM_RS))
		else begin
			errors++;
			$display("[ERROR] %0t: CDB tag %0d out of range", $time, dut_i.cdb.tag);
		end

	// the result stage holds off the ALU while its entry is full
	assert property (@(posedge clk) disable iff (!reset)
		dut_i.result_full |-> dut_i.rs_dispatched == '0)
		else begin
			errors++;
			$display("[ERROR] %0t: dispatch while the result register is full", $time);
		end

	// expected result straight from the operation table
	function automatic data_t model_alu(input logic [2:0] op, input logic sign,
		input data_t a, input data_t b);
		int unsigned sh;
		data_t ones;
		data_t r;
		sh = b[4:0];
		ones = '1;
		case (op)
			3'd0: r = sign ? a + (~b + data_t'(1)) : a + b;
			3'd1: r = a << sh;
			3'd2: begin
				if (sign) begin
					r = ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
				end else begin
					r = (a < b) ? data_t'(1) : data_t'(0);
				end
			end
			3'd3: r = a ^ b;
			3'd4: begin
				r = a >> sh;
				// arithmetic variant refills the vacated top bits with the old sign
				if (sign && a[`XLEN-1]) begin
					r = r | ~(ones >> sh);
				end
			end
			3'd5: r = a | b;
			3'd6: r = a & b;
			default: r = a;
		endcase
		return r;
	endfunction

	// one classic cycle, driven just after the edge and closed once ack is seen
	task automatic bus_access(input logic write, input logic [2:0] addr, input data_t wdata,
		output data_t rdata);
		@(posedge clk);
		#1;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		dat_w = wdata;
		do begin
			@(posedge clk);
			#1;
		end while (!ack);
		rdata = dat_r;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic load_imm(input logic [2:0] rd, input logic [15:0] imm);
		instr_word_t w;
		data_t unused;
		w = '0;
		w.rd = rd;
		w.imm = imm;
		model[rd] = {{(`XLEN - 16){imm[15]}}, imm};
		bus_access(1'b1, ADR_LOAD, data_t'(w), unused);
	endtask

	task automatic issue_op(input logic [2:0] op, input logic sign, input logic [2:0] rd,
		input logic [2:0] rs1, input logic [2:0] rs2);
		instr_word_t w;
		data_t unused;
		w = '0;
		w.op = alu_op_t'(op);
		w.sign = sign;
		w.rd = rd;
		w.rs1 = rs1;
		w.rs2 = rs2;
		model[rd] = model_alu(op, sign, model[rs1], model[rs2]);
		bus_access(1'b1, ADR_ISSUE, data_t'(w), unused);
	endtask

	task automatic read_pending(output data_t mask);
		bus_access(1'b0, ADR_PENDING, '0, mask);
	endtask

	task automatic check_value(input string what, input data_t got, input data_t exp);
		checks++;
		assert (got === exp)
			else begin
				errors++;
				$display("[ERROR] %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
			end
	endtask

	// keep polling the pending mask until none of the selected registers waits
	task automatic wait_clear(input logic [`NUM_REGS-1:0] sel);
		data_t mask;
		do begin
			read_pending(mask);
		end while ((mask[`NUM_REGS-1:0] & sel) != '0);
	endtask

	task automatic check_reg(input logic [2:0] r);
		data_t got;
		bus_access(1'b0, ADR_REG, data_t'(r), got);
		check_value($sformatf("r%0d", r), got, model[r]);
	endtask

	task automatic check_all_regs();
		wait_clear('1);
		for (int r = 0; r < `NUM_REGS; r++) begin
			check_reg(3'(r));
		end
	endtask

	task automatic load_all_random();
		for (int r = 0; r < `NUM_REGS; r++) begin
			load_imm(3'(r), 16'($random(seed)));
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == errors_before) ? "pass" : "fail");
	endtask

	initial begin
		data_t mask;
		int start;
		clk = 1'b0;
		reset = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		seed = 32'h3d1f;
		cycles = 0;
		checks = 0;
		errors = 0;
		tests = 0;
		for (int r = 0; r < `NUM_REGS; r++) begin
			model[r] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b1;

		// idle bus after reset, then immediates with both signs of the top bit
		start = errors;
		check_value("ack after reset", data_t'(ack), '0);
		read_pending(mask);
		check_value("pending mask", mask, '0);
		load_all_random();
		load_imm(3'd2, 16'h8001);
		load_imm(3'd3, 16'h7ffe);
		check_all_regs();
		report_test("reset and load", start);

		// every operation in both variants, operands fresh from the loads
		start = errors;
		for (int op = 0; op < 8; op++) begin
			for (int s = 0; s < 2; s++) begin
				load_imm(3'd1, 16'($random(seed)));
				load_imm(3'd2, 16'($random(seed)));
				issue_op(3'(op), 1'(s), 3'd3, 3'd1, 3'd2);
				wait_clear(8'h08);
				check_reg(3'd3);
			end
		end
		report_test("alu operations", start);

		// each instruction reads the destination of the one before
		start = errors;
		load_all_random();
		for (int i = 1; i < 7; i++) begin
			issue_op(3'($random(seed)), 1'($random(seed)), 3'(i), 3'(i - 1), 3'd7);
		end
		check_all_regs();
		report_test("dependent chain", start);

		// a long chain of more issues than stations fills every station
		// and the host has to wait for ack until one frees
		start = errors;
		load_all_random();
		for (int i = 0; i < 12; i++) begin
			issue_op(3'($random(seed)), 1'($random(seed)), 3'(i + 1), 3'(i),
				3'($random(seed)));
		end
		check_all_regs();
		report_test("back to back issue", start);

		// destination shows pending right after the issue and clears later
		start = errors;
		issue_op(3'd0, 1'b0, 3'd6, 3'd1, 3'd2);
		read_pending(mask);
		checks++;
		assert (mask[6])
			else begin
				errors++;
				$display("[ERROR] %0t: r6 not pending after issue, mask 0x%02h", $time,
					mask[`NUM_REGS-1:0]);
			end
		wait_clear(8'h40);
		check_reg(3'd6);
		report_test("pending mask", start);

		// r5 depends on r4, so the load lands while r5 still waits on a station
		start = errors;
		issue_op(3'd1, 1'b0, 3'd4, 3'd0, 3'd1);
		issue_op(3'd3, 1'b0, 3'd5, 3'd4, 3'd2);
		load_imm(3'd5, 16'hc35a);
		check_all_regs();
		report_test("load over pending", start);

		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tomasulo_top.f
+incdir+verilog
verilog/tomasulo_pkg.sv
verilog/rs_issue_if.sv
verilog/issue_unit.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/cdb_result.sv
verilog/tomasulo_top.sv
bench/tb_tomasulo_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator from the file list, run, and decide on the log contents

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tomasulo_top.f \
	--top-module tb_tomasulo_top -o sim_tomasulo > build.log 2>&1 &&
./obj_dir/sim_tomasulo > sim.log 2>&1 ||
{ echo "build or simulation did not complete"; exit 1; }

grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
